// File: src.f
+incdir+verification
verilog/fpu_mul_pkg.sv
verilog/fpu_mul_lzc.sv
verilog/fpu_mul_prenorm.sv
verilog/fpu_mul_exp_align.sv
verilog/fpu_mul_array.sv
verilog/fpu_mul_top.sv
verification/fpu_mul_tb.sv

// File: verification/fpu_mul_model.svh
////////////////////////////////////////
// multiplier reference model
// expected align-stage bundle for one
// operand pair, from the format rules
////////////////////////////////////////

`ifndef FPU_MUL_MODEL_SVH
`define FPU_MUL_MODEL_SVH

// leading zeros, scanning down from the msb
// all-zero fraction counts as 0
function automatic int lead_zeros(input logic [FRACT_W-1:0] f);
  int   n;
  logic found;
  n = 0;
  found = 1'b0;
  for (int i = FRACT_W - 1; i >= 0; i--) begin
    if (!found && f[i]) begin
      found = 1'b1;
      n = FRACT_W - 1 - i;
    end
  end
  return n;
endfunction

function automatic mul_result_t model_multiply(input fp_operand_t a,
                                               input fp_operand_t b,
                                               input nan_info_t   nan_v);
  mul_result_t r;
  int          nlza;
  int          nlzb;
  int          sum;
  int          shift;
  logic [23:0] na;
  logic [23:0] nb;
  logic [47:0] prod;
  logic        zero;
  zero = a.zero | b.zero;
  // exception flags
  r.flags.inv = (a.zero & b.inf) | (b.zero & a.inf);
  r.flags.inf = a.inf | b.inf;
  r.flags.nan = nan_v;
  r.sign = a.sign ^ b.sign;
  // normalize denormal fractions
  nlza = lead_zeros(a.fract24);
  nlzb = lead_zeros(b.fract24);
  na = a.fract24 << nlza;
  nb = b.fract24 << nlzb;
  // biased sum, wrapped into 10 bits
  sum = int'(a.exp10) - nlza + int'(b.exp10) - nlzb - EXP_BIAS;
  sum = ((sum % 1024) + 1024) % 1024;
  if (zero) begin
    sum = 0;
  end
  r.exp10sh0 = 10'(sum);
  // right-shift decision
  if (zero) begin
    r.shr = '0;
    r.exp10shr = '0;
  end else if (sum >= 512) begin
    shift = 1025 - sum;
    r.shr = (shift > 31) ? 5'd31 : 5'(shift);
    r.exp10shr = 10'd1;
  end else if (sum == 0) begin
    r.shr = 5'd1;
    r.exp10shr = 10'd1;
  end else begin
    r.shr = '0;
    r.exp10shr = 10'(sum);
  end
  // full product, 27 bits kept plus sticky
  prod = 48'(na) * 48'(nb);
  r.fract28 = zero ? '0 : {prod[47:21], |prod[20:0]};
  return r;
endfunction

`endif

// File: verification/fpu_mul_tb.sv
////////////////////////////////////////
// fp multiplier testbench
// random and directed operand pairs,
// stalls, flush and reset, checked
// against a queue of model results
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_tb
  import fpu_mul_pkg::*;
();

  logic        clk = 1'b0;
  logic        rst;
  logic        flush;
  logic        adv;
  logic        start;
  fp_operand_t opa;
  fp_operand_t opb;
  nan_info_t   nan;
  logic        rdy;
  mul_result_t res;

  // scoreboard with one entry per started operation
  mul_result_t exp_q[$];
  int          issue_q[$];
  string       name_q[$];
  int          adv_count;
  // inputs seen by the last edge
  logic        last_adv;
  logic        last_rst;
  logic        last_flush;
  logic        prev_rdy;
  mul_result_t prev_res;
  logic [31:0] lfsr;
  string       test_name;
  int          value_errs;
  int          proto_errs;
  int          timeout_errs;

  `include "fpu_mul_model.svh"

  fpu_mul_top uut (
    .clk     (clk),
    .rst     (rst),
    .flush_i (flush),
    .adv_i   (adv),
    .start_i (start),
    .opa_i   (opa),
    .opb_i   (opb),
    .nan_i   (nan),
    .rdy_o   (rdy),
    .res_o   (res)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic fp_operand_t make_operand(input logic s, input logic [9:0] e,
                                               input logic [23:0] f, input logic is_inf,
                                               input logic is_zero);
    fp_operand_t op;
    op.sign = s;
    op.exp10 = e;
    op.fract24 = f;
    op.inf = is_inf;
    op.zero = is_zero;
    return op;
  endfunction

  // hidden bit set and exponent 64..191
  function automatic fp_operand_t normal_operand();
    logic        s;
    logic [9:0]  e;
    logic [23:0] f;
    s = 1'(random_bits(1));
    e = 10'd64 + 10'(random_bits(7));
    f = 24'h800000 | 24'(random_bits(23));
    return make_operand(s, e, f, 1'b0, 1'b0);
  endfunction

  // hidden bit clear but never all zero
  function automatic fp_operand_t denormal_operand(input logic [9:0] e);
    logic        s;
    logic [23:0] f;
    s = 1'(random_bits(1));
    f = (24'(random_bits(23)) >> random_bits(3)) | 24'd1;
    return make_operand(s, e, f, 1'b0, 1'b0);
  endfunction

  // inputs change right after the edge
  task automatic drive(input logic s, input logic a_v, input fp_operand_t a,
                       input fp_operand_t b);
    start <= s;
    adv <= a_v;
    opa <= a;
    opb <= b;
    nan <= 3'(random_bits(3));
    @(posedge clk);
  endtask

  task automatic issue(input fp_operand_t a, input fp_operand_t b);
    drive(1'b1, 1'b1, a, b);
  endtask

  task automatic idle();
    drive(1'b0, 1'b1, opa, opb);
  endtask

  task automatic flush_pipe(input logic adv_v);
    flush <= 1'b1;
    start <= 1'b0;
    adv <= adv_v;
    @(posedge clk);
    flush <= 1'b0;
  endtask

  // run the pipe until every started op came out
  task automatic drain();
    int cycles;
    cycles = 0;
    start <= 1'b0;
    adv <= 1'b1;
    while (exp_q.size() != 0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      timeout_errs++;
      $display("ERROR %s: %0d results still missing after %0d cycles",
               test_name, exp_q.size(), cycles);
    end
  endtask

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_field(input string name, input string field,
                             input logic [31:0] expv, input logic [31:0] actv);
    assert (actv === expv) else begin
      value_errs++;
      $display("FAIL %s %s expected %0h actual %0h", name, field, expv, actv);
    end
  endtask

  task automatic check_result();
    mul_result_t e;
    string       name;
    int          due;
    if (exp_q.size() == 0) begin
      proto_errs++;
      $display("ERROR %s: rdy_o high with no operation in flight", test_name);
    end else begin
      e = exp_q.pop_front();
      due = issue_q.pop_front() + 3;
      name = name_q.pop_front();
      // due on the fourth advancing edge counting the start edge
      check_field(name, "latency", due, adv_count);
      check_field(name, "sign", e.sign, res.sign);
      check_field(name, "fract28", e.fract28, res.fract28);
      check_field(name, "exp10sh0", e.exp10sh0, res.exp10sh0);
      check_field(name, "shr", e.shr, res.shr);
      check_field(name, "exp10shr", e.exp10shr, res.exp10shr);
      check_field(name, "flags", e.flags, res.flags);
    end
  endtask

  // sample outputs half a cycle after each edge
  always @(negedge clk) begin
    if (last_rst || last_flush) begin
      assert (rdy === 1'b0) else begin
        proto_errs++;
        $display("ERROR %s: rdy_o not cleared by reset or flush", test_name);
      end
      // in-flight ops are gone
      exp_q.delete();
      issue_q.delete();
      name_q.delete();
    end else if (!last_adv) begin
      // stalled edge leaves everything frozen
      assert (rdy === prev_rdy && res === prev_res) else begin
        proto_errs++;
        $display("ERROR %s: outputs changed while adv_i was low", test_name);
      end
    end else begin
      adv_count++;
      if (rdy === 1'b1) begin
        check_result();
      end else if (rdy !== 1'b0) begin
        proto_errs++;
        $display("ERROR %s: rdy_o is unknown", test_name);
      end else if (exp_q.size() != 0 && adv_count >= issue_q[0] + 3) begin
        proto_errs++;
        $display("ERROR %s: result of %s did not appear", test_name, name_q[0]);
        void'(exp_q.pop_front());
        void'(issue_q.pop_front());
        void'(name_q.pop_front());
      end
    end
    // op taken by the next edge
    if (start && adv && !rst && !flush) begin
      exp_q.push_back(model_multiply(opa, opb, nan));
      issue_q.push_back(adv_count + 1);
      name_q.push_back(test_name);
    end
    prev_rdy = rdy;
    prev_res = res;
    last_adv = adv;
    last_rst = rst;
    last_flush = flush;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    int          issued;
    int          cycles;
    logic        go;
    fp_operand_t a;
    fp_operand_t b;
    fp_operand_t zero_op;
    fp_operand_t inf_op;
    rst = 1'b1;
    flush = 1'b0;
    adv = 1'b0;
    start = 1'b0;
    opa = '0;
    opb = '0;
    nan = '0;
    lfsr = 32'ha651_7361;
    adv_count = 0;
    last_adv = 1'b0;
    last_rst = 1'b1;
    last_flush = 1'b0;
    value_errs = 0;
    proto_errs = 0;
    timeout_errs = 0;
    test_name = "reset";
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // rdy_o stays low with nothing started
    repeat (4) idle();

    test_name = "random_normal";
    repeat (30) begin
      a = normal_operand();
      b = normal_operand();
      issue(a, b);
    end
    drain();

    test_name = "exceptions";
    zero_op = make_operand(1'b0, 10'd0, 24'd0, 1'b0, 1'b1);
    inf_op = make_operand(1'b1, 10'd255, 24'h800000, 1'b1, 1'b0);
    issue(zero_op, inf_op);
    issue(inf_op, zero_op);
    issue(inf_op, normal_operand());
    issue(normal_operand(), inf_op);
    issue(inf_op, inf_op);
    issue(normal_operand(), zero_op);
    issue(zero_op, zero_op);
    // zero flag wins over stray fraction bits
    issue(make_operand(1'b0, 10'd0, 24'h5a5a5a, 1'b0, 1'b1), normal_operand());
    issue(normal_operand(), make_operand(1'b1, 10'd3, 24'hc0ffee, 1'b0, 1'b1));
    drain();

    test_name = "denormal";
    repeat (10) begin
      a = denormal_operand(10'd1);
      b = normal_operand();
      issue(a, b);
    end
    // saturates at 31
    issue(denormal_operand(10'd1), denormal_operand(10'd1));
    // exponent sums of -1, -29, 0 and 15
    issue(make_operand(1'b0, 10'd100, 24'h800000, 1'b0, 1'b0),
          make_operand(1'b0, 10'd26, 24'hc00000, 1'b0, 1'b0));
    issue(make_operand(1'b0, 10'd1, 24'h800000, 1'b0, 1'b0),
          make_operand(1'b1, 10'd97, 24'ha00001, 1'b0, 1'b0));
    issue(make_operand(1'b0, 10'd1, 24'h400000, 1'b0, 1'b0),
          make_operand(1'b0, 10'd127, 24'hffffff, 1'b0, 1'b0));
    issue(make_operand(1'b1, 10'd127, 24'h000100, 1'b0, 1'b0),
          make_operand(1'b0, 10'd30, 24'h812345, 1'b0, 1'b0));
    drain();

    test_name = "back_pressure";
    issued = 0;
    cycles = 0;
    while (issued < 40 && cycles < 400) begin
      a = normal_operand();
      b = (random_bits(2) == 0) ? denormal_operand(10'd1) : normal_operand();
      go = (random_bits(2) != 0);
      if (go) begin
        issued++;
      end
      drive(1'b1, go, a, b);
      cycles++;
    end
    if (issued < 40) begin
      timeout_errs++;
      $display("ERROR %s: only %0d operations started", test_name, issued);
    end
    drain();

    test_name = "flush";
    repeat (3) issue(normal_operand(), normal_operand());
    // flush during a stall
    flush_pipe(1'b0);
    idle();
    issue(normal_operand(), normal_operand());
    drain();
    repeat (4) issue(normal_operand(), normal_operand());
    flush_pipe(1'b1);
    repeat (3) idle();
    issue(denormal_operand(10'd2), normal_operand());
    drain();

    test_name = "mid_reset";
    repeat (3) issue(normal_operand(), normal_operand());
    rst <= 1'b1;
    start <= 1'b0;
    adv <= 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (4) idle();
    issue(normal_operand(), normal_operand());
    drain();

    test_name = "end";
    $display("errors: value %0d, protocol %0d, timeout %0d",
             value_errs, proto_errs, timeout_errs);
    if (value_errs + proto_errs + timeout_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/fpu_mul_array.sv
////////////////////////////////////////
// fraction multiplier array
// operand halves, four 16x16 partial
// products, then a combinational sum
// into a 28-bit fraction with sticky
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_array
  import fpu_mul_pkg::*;
(
  input  wire logic              clk,
  input  wire logic              adv_i,
  input  wire logic [FRACT_W-1:0] fract24a_i,
  input  wire logic [FRACT_W-1:0] fract24b_i,
  output logic [OUT_FRACT_W-1:0] fract28_o
);

  // fraction padded up to two halves
  localparam int PAD_W = 2 * HALF_W - FRACT_W;

  logic [2*HALF_W-1:0] mul32a;
  logic [2*HALF_W-1:0] mul32b;
  // stage 1 operand halves
  logic [HALF_W-1:0]   al;
  logic [HALF_W-1:0]   ah;
  logic [HALF_W-1:0]   bl;
  logic [HALF_W-1:0]   bh;
  // stage 2 partial products
  logic [2*HALF_W-1:0] albl;
  logic [2*HALF_W-1:0] albh;
  logic [2*HALF_W-1:0] ahbl;
  logic [2*HALF_W-1:0] ahbh;
  logic [PROD_W-1:0]   prod;

  assign mul32a = {fract24a_i, {PAD_W{1'b0}}};
  assign mul32b = {fract24b_i, {PAD_W{1'b0}}};

  // stage 1, split operands
  always_ff @(posedge clk) begin
    if (adv_i) begin
      al <= mul32a[HALF_W-1:0];
      ah <= mul32a[2*HALF_W-1:HALF_W];
      bl <= mul32b[HALF_W-1:0];
      bh <= mul32b[2*HALF_W-1:HALF_W];
    end
  end

  // stage 2, partial products
  always_ff @(posedge clk) begin
    if (adv_i) begin
      albl <= al * bl;
      albh <= al * bh;
      ahbl <= ah * bl;
      ahbh <= ah * bh;
    end
  end

  // upper 48 bits of the 64-bit product
  // low 16 bits of albl are always zero because of the padding
  assign prod = {ahbh, {HALF_W{1'b0}}}
              + {{HALF_W{1'b0}}, ahbl}
              + {{HALF_W{1'b0}}, albh}
              + {{(2*HALF_W){1'b0}}, albl[2*HALF_W-1:HALF_W]};

  // 27 result bits plus sticky
  assign fract28_o = {prod[PROD_W-1:PROD_W-OUT_FRACT_W+1],
                      |prod[PROD_W-OUT_FRACT_W:0]};

endmodule

`default_nettype wire

// File: verilog/fpu_mul_exp_align.sv
////////////////////////////////////////
// multiplier exponent path, stages 1-2
// normalizes fractions for the array,
// sums exponents and picks the right
// shift for the later align stage
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_exp_align
  import fpu_mul_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          adv_i,
  input  wire prenorm_t      pre_i,
  output logic [FRACT_W-1:0] fract24a_o,
  output logic [FRACT_W-1:0] fract24b_o,
  output logic [SHR_W-1:0]   shr_o,
  output logic [EXP_W-1:0]   exp10shr_o,
  output logic [EXP_W-1:0]   exp10sh0_o
);

  logic [EXP_W-1:0] shla_ext;
  logic [EXP_W-1:0] shlb_ext;
  logic [EXP_W-1:0] exp_sum;
  logic [EXP_W-1:0] exp_c;
  // stage 1 registers
  logic [EXP_W-1:0] s1_exp_c;
  logic             s1_opc_0;
  // stage 2 decision
  logic             exp_zero;
  logic [EXP_W-1:0] shr_neg;
  logic [SHR_W-1:0] shr_sat;
  logic [SHR_W-1:0] shr_d;
  logic [EXP_W-1:0] exp10shr_d;

  ////////////////////////////////////////
  // stage 1: normalize and sum
  ////////////////////////////////////////

  // shift out leading zeros, then zero-force
  assign fract24a_o = (pre_i.fract24a << pre_i.shla) & {FRACT_W{~pre_i.opc_0}};
  assign fract24b_o = (pre_i.fract24b << pre_i.shlb) & {FRACT_W{~pre_i.opc_0}};

  assign shla_ext = {{(EXP_W-SHR_W){1'b0}}, pre_i.shla};
  assign shlb_ext = {{(EXP_W-SHR_W){1'b0}}, pre_i.shlb};

  // ea - shla + eb - shlb - bias, wraps mod 1024
  assign exp_sum = pre_i.exp10a - shla_ext + pre_i.exp10b - shlb_ext
                 - EXP_W'(EXP_BIAS);

  assign exp_c = exp_sum & {EXP_W{~pre_i.opc_0}};

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_exp_c <= exp_c;
      s1_opc_0 <= pre_i.opc_0;
    end
  end

  ////////////////////////////////////////
  // stage 2: right-shift decision
  ////////////////////////////////////////

  assign exp_zero = ~|s1_exp_c;

  // negative sum: 1024 - e + 1
  assign shr_neg = EXP_W'(11'h401 - {1'b0, s1_exp_c});

  // clamp at 31
  assign shr_sat = shr_neg[SHR_W-1:0] | {SHR_W{|shr_neg[EXP_W-1:SHR_W]}};

  always_comb begin
    if (s1_opc_0) begin
      // zero result
      shr_d      = '0;
      exp10shr_d = '0;
    end else if (s1_exp_c[EXP_W-1]) begin
      // negative exponent, denormal output
      shr_d      = shr_sat;
      exp10shr_d = EXP_W'(1);
    end else begin
      // zero sum shifts by one, else no shift
      shr_d      = {{(SHR_W-1){1'b0}}, exp_zero};
      exp10shr_d = s1_exp_c | {{(EXP_W-1){1'b0}}, exp_zero};
    end
  end

  always_ff @(posedge clk) begin
    if (adv_i) begin
      shr_o      <= shr_d;
      exp10shr_o <= exp10shr_d;
      exp10sh0_o <= s1_exp_c;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_mul_lzc.sv
////////////////////////////////////////
// leading-zero counter
// priority encoder over a 24-bit
// fraction, zero input gives zero
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_lzc
  import fpu_mul_pkg::*;
(
  input  wire logic [FRACT_W-1:0] fract24_i,
  output logic      [SHR_W-1:0]   nlz_o
);

  // scan lsb to msb, highest set bit wins
  always_comb begin
    nlz_o = '0;
    for (int i = 0; i < FRACT_W; i++) begin
      if (fract24_i[i]) begin
        nlz_o = SHR_W'(FRACT_W - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_mul_pkg.sv
////////////////////////////////////////
// fpu multiplier shared definitions
// single-precision format constants and
// the bundles passed between the stages
////////////////////////////////////////

`default_nettype none

package fpu_mul_pkg;

  // format widths
  localparam int EXP_W       = 10;
  localparam int FRACT_W     = 24;
  localparam int SHR_W       = 5;
  localparam int OUT_FRACT_W = 28;
  localparam int HALF_W      = 16;
  localparam int PROD_W      = 48;
  localparam int EXP_BIAS    = 127;

  // one unpacked operand
  typedef struct packed {
    logic               sign;
    logic [EXP_W-1:0]   exp10;
    logic [FRACT_W-1:0] fract24;  // hidden bit included
    logic               inf;
    logic               zero;
  } fp_operand_t;

  // nan info, carried unchanged
  typedef struct packed {
    logic snan;
    logic qnan;
    logic anan_sign;
  } nan_info_t;

  // exception flags down the pipe
  typedef struct packed {
    logic      inv;
    logic      inf;
    nan_info_t nan;
  } mul_flags_t;

  // stage 0 register contents
  typedef struct packed {
    mul_flags_t         flags;
    logic               opc_0;     // force result to zero
    logic               signc;
    logic [EXP_W-1:0]   exp10a;
    logic [FRACT_W-1:0] fract24a;
    logic [SHR_W-1:0]   shla;
    logic [EXP_W-1:0]   exp10b;
    logic [FRACT_W-1:0] fract24b;
    logic [SHR_W-1:0]   shlb;
  } prenorm_t;

  // output bundle for the align stage
  typedef struct packed {
    logic                   sign;
    logic [SHR_W-1:0]       shr;
    logic [EXP_W-1:0]       exp10shr;
    logic [EXP_W-1:0]       exp10sh0;
    logic [OUT_FRACT_W-1:0] fract28;   // {r,s} appended
    mul_flags_t             flags;
  } mul_result_t;

endpackage

`default_nettype wire

// File: verilog/fpu_mul_prenorm.sv
////////////////////////////////////////
// multiplier stage 0
// exception detection, leading-zero
// counts and operand registers
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_prenorm
  import fpu_mul_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        adv_i,
  input  wire fp_operand_t opa_i,
  input  wire fp_operand_t opb_i,
  input  wire nan_info_t   nan_i,
  output prenorm_t         pre_o
);

  logic [SHR_W-1:0] nlza;
  logic [SHR_W-1:0] nlzb;
  logic             inv;
  logic             inf;
  logic             opc_0;
  logic             signc;

  ////////////////////////////////////////
  // exceptions
  ////////////////////////////////////////

  // 0 * inf, either order
  assign inv = (opa_i.zero & opb_i.inf) | (opb_i.zero & opa_i.inf);

  // any infinite input
  assign inf = opa_i.inf | opb_i.inf;

  // zero operand zeroes the whole datapath
  assign opc_0 = opa_i.zero | opb_i.zero;

  // product sign
  assign signc = opa_i.sign ^ opb_i.sign;

  ////////////////////////////////////////
  // leading zeros for denormals
  ////////////////////////////////////////

  fpu_mul_lzc u_lzc_a (
    .fract24_i (opa_i.fract24),
    .nlz_o     (nlza)
  );

  fpu_mul_lzc u_lzc_b (
    .fract24_i (opb_i.fract24),
    .nlz_o     (nlzb)
  );

  ////////////////////////////////////////
  // stage 0 register
  ////////////////////////////////////////

  // payload only, validity lives in the top ready chain
  always_ff @(posedge clk) begin
    if (adv_i) begin
      // flags
      pre_o.flags.inv <= inv;
      pre_o.flags.inf <= inf;
      pre_o.flags.nan <= nan_i;
      // computation
      pre_o.opc_0    <= opc_0;
      pre_o.signc    <= signc;
      pre_o.exp10a   <= opa_i.exp10;
      pre_o.fract24a <= opa_i.fract24;
      pre_o.shla     <= nlza;
      pre_o.exp10b   <= opb_i.exp10;
      pre_o.fract24b <= opb_i.fract24;
      pre_o.shlb     <= nlzb;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_mul_top.sv
////////////////////////////////////////
// pipelined fp multiplier datapath
// four advancing stages from unpacked
// operands to the align-stage bundle,
// with a ready chain and flush
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module fpu_mul_top
  import fpu_mul_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst,
  input  wire logic        flush_i,
  input  wire logic        adv_i,
  input  wire logic        start_i,
  input  wire fp_operand_t opa_i,
  input  wire fp_operand_t opb_i,
  input  wire nan_info_t   nan_i,
  output logic             rdy_o,
  output mul_result_t      res_o
);

  prenorm_t               pre;
  logic [FRACT_W-1:0]     fract24a_n;
  logic [FRACT_W-1:0]     fract24b_n;
  logic [SHR_W-1:0]       shr;
  logic [EXP_W-1:0]       exp10shr;
  logic [EXP_W-1:0]       exp10sh0;
  logic [OUT_FRACT_W-1:0] fract28;
  // ready chain
  logic                   s0_ready;
  logic                   s1_ready;
  logic                   s2_ready;
  // side info delayed alongside the datapath
  mul_flags_t             s1_flags;
  logic                   s1_opc_0;
  logic                   s1_signc;
  mul_flags_t             s2_flags;
  logic                   s2_opc_0;
  logic                   s2_signc;

  ////////////////////////////////////////
  // datapath
  ////////////////////////////////////////

  fpu_mul_prenorm u_prenorm (
    .clk   (clk),
    .adv_i (adv_i),
    .opa_i (opa_i),
    .opb_i (opb_i),
    .nan_i (nan_i),
    .pre_o (pre)
  );

  fpu_mul_exp_align u_exp_align (
    .clk        (clk),
    .adv_i      (adv_i),
    .pre_i      (pre),
    .fract24a_o (fract24a_n),
    .fract24b_o (fract24b_n),
    .shr_o      (shr),
    .exp10shr_o (exp10shr),
    .exp10sh0_o (exp10sh0)
  );

  fpu_mul_array u_array (
    .clk        (clk),
    .adv_i      (adv_i),
    .fract24a_i (fract24a_n),
    .fract24b_i (fract24b_n),
    .fract28_o  (fract28)
  );

  ////////////////////////////////////////
  // ready chain
  ////////////////////////////////////////

  // flush kills everything in flight, even on a stall
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      s0_ready <= 1'b0;
      s1_ready <= 1'b0;
      s2_ready <= 1'b0;
      rdy_o    <= 1'b0;
    end else if (adv_i) begin
      s0_ready <= start_i;
      s1_ready <= s0_ready;
      s2_ready <= s1_ready;
      rdy_o    <= s2_ready;
    end
  end

  ////////////////////////////////////////
  // flags and sign through stages 1-2
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s1_flags <= pre.flags;
      s1_opc_0 <= pre.opc_0;
      s1_signc <= pre.signc;
      s2_flags <= s1_flags;
      s2_opc_0 <= s1_opc_0;
      s2_signc <= s1_signc;
    end
  end

  // output register, product sum lands here
  always_ff @(posedge clk) begin
    if (adv_i) begin
      res_o.sign     <= s2_signc;
      res_o.shr      <= shr;
      res_o.exp10shr <= exp10shr;
      res_o.exp10sh0 <= exp10sh0;
      // zero operand gives a clean zero fraction
      res_o.fract28  <= fract28 & {OUT_FRACT_W{~s2_opc_0}};
      res_o.flags    <= s2_flags;
    end
  end

endmodule

`default_nettype wire
